// ==== src/rob_defs.svh ====
// reorder buffer sizing
`ifndef ROB_DEFS_SVH
`define ROB_DEFS_SVH

// entry store
`define ROB_DEPTH 8
`define ROB_IDX_W $clog2(`ROB_DEPTH)

// pipeline widths
`define DISPATCH_WIDTH 2
`define COMMIT_WIDTH 2

// program counter width
`define ADDR_W 32

// trap entry point taken on any exception
`define EXC_VECTOR 32'h0000_1c00

`endif

// ==== src/uop_pkg.sv ====
// micro-op and execution result types

`include "rob_defs.svh"

package uop_pkg;

  // micro-op class, drives commit rules
  typedef enum logic [1:0] {
    UOP_ALU    = 2'd0,
    UOP_BRANCH = 2'd1,
    UOP_LOAD   = 2'd2,
    UOP_STORE  = 2'd3
  } uop_kind_t;

  // integer ALU result, branches carry their resolved target
  typedef struct packed {
    logic [`ROB_IDX_W-1:0] idx;
    logic                  redirect;
    logic [`ADDR_W-1:0]    target;
  } alu_result_t;

  // load/store unit result
  typedef struct packed {
    logic [`ROB_IDX_W-1:0] idx;
    uop_kind_t             kind;
    logic                  exc;
    logic [`ADDR_W-1:0]    fault_addr;
  } mem_result_t;

endpackage

// ==== src/rob_pkg.sv ====
// reorder buffer entry and retire types

`include "rob_defs.svh"

package rob_pkg;

  // msb is the wrap bit, the rest indexes the entry array
  typedef logic [`ROB_IDX_W:0] rob_ptr_t;

  // physical destination register
  typedef logic [5:0] preg_t;

  // ==============================
  // stored entry
  // ==============================
  typedef struct packed {
    logic                complete;
    uop_pkg::uop_kind_t  kind;
    logic [`ADDR_W-1:0]  pc;
    preg_t               preg;
    logic                exc;
    logic                redirect;
    // branch target, or the bad address of a faulting access
    logic [`ADDR_W-1:0]  target;
  } rob_entry_t;

  // ==============================
  // one retire slot
  // ==============================
  typedef struct packed {
    logic                valid;
    logic [`ADDR_W-1:0]  pc;
    uop_pkg::uop_kind_t  kind;
    preg_t               preg;
  } retire_t;

endpackage

// ==== src/wb_port.sv ====
// write-back handshake bridge

`timescale 1ns/1ps

module wb_port #(
  parameter type payload_t = logic [31:0]
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     req,
  input  payload_t data,
  output logic     ack,
  output logic     wr_valid,
  output payload_t wr_data,
  input  logic     wr_ready
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_OFFER,
    ST_ACK,
    ST_WAIT_LOW
  } state_t;

  state_t state_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ST_IDLE;
    end else begin
      case (state_q)
        ST_IDLE:     if (req) state_q <= ST_OFFER;
        // hold the write until the buffer takes it
        ST_OFFER:    if (wr_ready) state_q <= ST_ACK;
        ST_ACK:      if (!req) state_q <= ST_WAIT_LOW;
        // one idle cycle with ack low before the next request
        ST_WAIT_LOW: state_q <= ST_IDLE;
        default:     state_q <= ST_IDLE;
      endcase
    end
  end

  // payload captured as req rises
  always_ff @(posedge clk) begin
    if (state_q == ST_IDLE && req) begin
      wr_data <= data;
    end
  end

  assign wr_valid = (state_q == ST_OFFER);
  assign ack      = (state_q == ST_ACK);

endmodule

// ==== src/reorder_buffer.sv ====
// reorder buffer entry store

`timescale 1ns/1ps
`include "rob_defs.svh"

module reorder_buffer (
  input  logic                                             clk,
  input  logic                                             rst_n,
  input  logic                                             flush,
  // dispatch
  input  logic                                             disp_req,
  input  logic [`DISPATCH_WIDTH-1:0]                       disp_valid,
  input  uop_pkg::uop_kind_t [`DISPATCH_WIDTH-1:0]         disp_kind,
  input  logic [`DISPATCH_WIDTH-1:0][`ADDR_W-1:0]          disp_pc,
  input  rob_pkg::preg_t [`DISPATCH_WIDTH-1:0]             disp_preg,
  output logic                                             disp_ack,
  output rob_pkg::rob_ptr_t [`DISPATCH_WIDTH-1:0]          disp_idx,
  // write-back
  input  logic                                             alu_wr_valid,
  input  uop_pkg::alu_result_t                             alu_wr_data,
  output logic                                             alu_wr_ready,
  input  logic                                             mem_wr_valid,
  input  uop_pkg::mem_result_t                             mem_wr_data,
  output logic                                             mem_wr_ready,
  // commit
  output rob_pkg::rob_entry_t [`COMMIT_WIDTH-1:0]          head_entry,
  output logic [`COMMIT_WIDTH-1:0]                         commit_valid
);

  rob_pkg::rob_entry_t entries [`ROB_DEPTH];

  rob_pkg::rob_ptr_t head_q;
  rob_pkg::rob_ptr_t tail_q;
  logic [`ROB_IDX_W:0] count_q;

  rob_pkg::rob_ptr_t [`DISPATCH_WIDTH-1:0] slot_ptr;
  rob_pkg::rob_ptr_t [`COMMIT_WIDTH-1:0]   rd_ptr;
  logic [`ROB_IDX_W:0] alloc_n;
  logic [`ROB_IDX_W:0] commit_n;
  logic alloc_fire;
  logic first_ok;
  logic pair_ok;

  // ==============================
  // allocation
  // ==============================
  // valid slots pack densely from the tail
  always_comb begin
    alloc_n = '0;
    for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
      slot_ptr[i] = tail_q + alloc_n;
      if (disp_valid[i]) begin
        alloc_n = alloc_n + 1'b1;
      end
    end
  end

  // once per handshake, and only with room for a full group
  assign alloc_fire = disp_req && !disp_ack && !flush &&
                      (count_q <= `ROB_DEPTH - `DISPATCH_WIDTH);

  // ==============================
  // write-back ready
  // ==============================
  assign alu_wr_ready = 1'b1;
  // stores and faults wait until they are the oldest entry
  assign mem_wr_ready = (mem_wr_data.kind == uop_pkg::UOP_LOAD && !mem_wr_data.exc) ||
                        (mem_wr_data.idx == head_q[`ROB_IDX_W-1:0]);

  // ==============================
  // commit selection
  // ==============================
  always_comb begin
    for (int i = 0; i < `COMMIT_WIDTH; i++) begin
      rd_ptr[i] = head_q + rob_pkg::rob_ptr_t'(i);
      head_entry[i] = entries[rd_ptr[i][`ROB_IDX_W-1:0]];
    end
  end

  assign first_ok = (count_q != '0) && head_entry[0].complete;

  // one branch per cycle, nothing pairs behind a fault or redirect
  assign pair_ok = (count_q > 1) && head_entry[1].complete &&
                   !head_entry[1].exc && !head_entry[1].redirect &&
                   head_entry[0].kind != uop_pkg::UOP_BRANCH &&
                   !head_entry[0].exc && !head_entry[0].redirect;

  assign commit_valid = {first_ok && pair_ok, first_ok};

  always_comb begin
    commit_n = '0;
    for (int i = 0; i < `COMMIT_WIDTH; i++) begin
      if (commit_valid[i]) begin
        commit_n = commit_n + 1'b1;
      end
    end
  end

  // ==============================
  // pointers and handshake state
  // ==============================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      head_q   <= '0;
      tail_q   <= '0;
      count_q  <= '0;
      disp_ack <= 1'b0;
    end else begin
      if (flush) begin
        head_q  <= '0;
        tail_q  <= '0;
        count_q <= '0;
      end else begin
        head_q  <= head_q + commit_n;
        tail_q  <= alloc_fire ? tail_q + alloc_n : tail_q;
        count_q <= count_q + (alloc_fire ? alloc_n : '0) - commit_n;
      end
      if (alloc_fire) begin
        disp_ack <= 1'b1;
      end else if (!disp_req) begin
        disp_ack <= 1'b0;
      end
    end
  end

  // entry array, written by dispatch and both write-back ports
  always_ff @(posedge clk) begin
    if (alloc_fire) begin
      for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
        if (disp_valid[i]) begin
          entries[slot_ptr[i][`ROB_IDX_W-1:0]].complete <= 1'b0;
          entries[slot_ptr[i][`ROB_IDX_W-1:0]].kind     <= disp_kind[i];
          entries[slot_ptr[i][`ROB_IDX_W-1:0]].pc       <= disp_pc[i];
          entries[slot_ptr[i][`ROB_IDX_W-1:0]].preg     <= disp_preg[i];
          entries[slot_ptr[i][`ROB_IDX_W-1:0]].exc      <= 1'b0;
          entries[slot_ptr[i][`ROB_IDX_W-1:0]].redirect <= 1'b0;
        end
      end
      disp_idx <= slot_ptr;
    end
    // results landing in a flush cycle are dropped
    if (!flush && alu_wr_valid && alu_wr_ready) begin
      entries[alu_wr_data.idx].complete <= 1'b1;
      entries[alu_wr_data.idx].redirect <= alu_wr_data.redirect;
      entries[alu_wr_data.idx].target   <= alu_wr_data.target;
    end
    if (!flush && mem_wr_valid && mem_wr_ready) begin
      entries[mem_wr_data.idx].complete <= 1'b1;
      entries[mem_wr_data.idx].exc      <= mem_wr_data.exc;
      entries[mem_wr_data.idx].target   <= mem_wr_data.fault_addr;
    end
  end

endmodule

// ==== src/commit_ctrl.sv ====
// retire register and redirect generation

`timescale 1ns/1ps
`include "rob_defs.svh"

module commit_ctrl (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  rob_pkg::rob_entry_t [`COMMIT_WIDTH-1:0] head_entry,
  input  logic [`COMMIT_WIDTH-1:0]                commit_valid,
  output rob_pkg::retire_t [`COMMIT_WIDTH-1:0]    retire,
  output logic                                    flush,
  output logic                                    redirect_valid,
  output logic [`ADDR_W-1:0]                      redirect_pc
);

  logic               hit;
  logic [`ADDR_W-1:0] hit_pc;

  // oldest retiring entry that needs a redirect
  always_comb begin
    hit    = 1'b0;
    hit_pc = '0;
    for (int i = 0; i < `COMMIT_WIDTH; i++) begin
      if (!hit && commit_valid[i] && (head_entry[i].exc || head_entry[i].redirect)) begin
        hit    = 1'b1;
        hit_pc = head_entry[i].exc ? `EXC_VECTOR : head_entry[i].target;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      retire <= '0;
      flush  <= 1'b0;
    end else begin
      for (int i = 0; i < `COMMIT_WIDTH; i++) begin
        // younger entries seen during the flush cycle are discarded
        retire[i].valid <= commit_valid[i] && !flush;
        retire[i].pc    <= head_entry[i].pc;
        retire[i].kind  <= head_entry[i].kind;
        retire[i].preg  <= head_entry[i].preg;
      end
      flush <= hit && !flush;
    end
  end

  always_ff @(posedge clk) begin
    if (hit && !flush) begin
      redirect_pc <= hit_pc;
    end
  end

  assign redirect_valid = flush;

endmodule

// ==== src/rob_top.sv ====
// out-of-order commit subsystem

`timescale 1ns/1ps
`include "rob_defs.svh"

module rob_top (
  input  logic                                     clk,
  input  logic                                     rst_n,
  // dispatch
  input  logic                                     disp_req,
  input  logic [`DISPATCH_WIDTH-1:0]               disp_valid,
  input  uop_pkg::uop_kind_t [`DISPATCH_WIDTH-1:0] disp_kind,
  input  logic [`DISPATCH_WIDTH-1:0][`ADDR_W-1:0]  disp_pc,
  input  rob_pkg::preg_t [`DISPATCH_WIDTH-1:0]     disp_preg,
  output logic                                     disp_ack,
  output rob_pkg::rob_ptr_t [`DISPATCH_WIDTH-1:0]  disp_idx,
  // write-back
  input  logic                                     alu_req,
  input  uop_pkg::alu_result_t                     alu_data,
  output logic                                     alu_ack,
  input  logic                                     mem_req,
  input  uop_pkg::mem_result_t                     mem_data,
  output logic                                     mem_ack,
  // retire and redirect
  output rob_pkg::retire_t [`COMMIT_WIDTH-1:0]     retire,
  output logic                                     redirect_valid,
  output logic [`ADDR_W-1:0]                       redirect_pc
);

  logic                 alu_wr_valid;
  logic                 alu_wr_ready;
  uop_pkg::alu_result_t alu_wr_data;
  logic                 mem_wr_valid;
  logic                 mem_wr_ready;
  uop_pkg::mem_result_t mem_wr_data;
  logic                 flush;

  rob_pkg::rob_entry_t [`COMMIT_WIDTH-1:0] head_entry;
  logic [`COMMIT_WIDTH-1:0]                commit_valid;

  wb_port #(.payload_t(uop_pkg::alu_result_t)) u_alu_wb (
    .clk      (clk),
    .rst_n    (rst_n),
    .req      (alu_req),
    .data     (alu_data),
    .ack      (alu_ack),
    .wr_valid (alu_wr_valid),
    .wr_data  (alu_wr_data),
    .wr_ready (alu_wr_ready)
  );

  wb_port #(.payload_t(uop_pkg::mem_result_t)) u_mem_wb (
    .clk      (clk),
    .rst_n    (rst_n),
    .req      (mem_req),
    .data     (mem_data),
    .ack      (mem_ack),
    .wr_valid (mem_wr_valid),
    .wr_data  (mem_wr_data),
    .wr_ready (mem_wr_ready)
  );

  reorder_buffer u_rob (
    .clk          (clk),
    .rst_n        (rst_n),
    .flush        (flush),
    .disp_req     (disp_req),
    .disp_valid   (disp_valid),
    .disp_kind    (disp_kind),
    .disp_pc      (disp_pc),
    .disp_preg    (disp_preg),
    .disp_ack     (disp_ack),
    .disp_idx     (disp_idx),
    .alu_wr_valid (alu_wr_valid),
    .alu_wr_data  (alu_wr_data),
    .alu_wr_ready (alu_wr_ready),
    .mem_wr_valid (mem_wr_valid),
    .mem_wr_data  (mem_wr_data),
    .mem_wr_ready (mem_wr_ready),
    .head_entry   (head_entry),
    .commit_valid (commit_valid)
  );

  commit_ctrl u_cmt (
    .clk            (clk),
    .rst_n          (rst_n),
    .head_entry     (head_entry),
    .commit_valid   (commit_valid),
    .retire         (retire),
    .flush          (flush),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc)
  );

endmodule

// ==== verification/tb_clock_gen.sv ====
// testbench clock and reset

`timescale 1ns/1ps

module tb_clock_gen #(
  parameter real PERIOD     = 8.0,
  parameter int  RST_CYCLES = 8
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk   = 1'b0;
    rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
  end

  always #(PERIOD / 2.0) clk = ~clk;

endmodule

// ==== verification/rob_properties.sv ====
// reorder buffer assertions

`timescale 1ns/1ps
`include "rob_defs.svh"

module rob_properties (
  input logic                     clk,
  input logic                     rst_n,
  input logic                     flush,
  input logic [`ROB_IDX_W:0]      count,
  input rob_pkg::rob_ptr_t        head,
  input logic [`COMMIT_WIDTH-1:0] commit_valid
);

  a_occupancy : assert property (@(posedge clk) disable iff (!rst_n)
    count <= `ROB_DEPTH)
    else $error("occupancy above buffer depth");

  // flush is a single-cycle pulse
  a_flush_pulse : assert property (@(posedge clk) disable iff (!rst_n)
    flush |=> !flush)
    else $error("flush held for more than one cycle");

  // a pair retires the two oldest entries together
  a_pair_order : assert property (@(posedge clk) disable iff (!rst_n)
    (commit_valid[1] && !flush) |=> head == rob_pkg::rob_ptr_t'($past(head) + 2))
    else $error("second slot committed without the first");

endmodule

bind reorder_buffer rob_properties u_props (
  .clk          (clk),
  .rst_n        (rst_n),
  .flush        (flush),
  .count        (count_q),
  .head         (head_q),
  .commit_valid (commit_valid)
);

// ==== verification/rob_tb.sv ====
// reorder buffer subsystem testbench

`timescale 1ns/1ps
`include "rob_defs.svh"

module rob_tb;

  localparam int TIMEOUT = 400;
  localparam int N_ROWS  = 6;

  // entry index carried by write-back results
  typedef logic [`ROB_IDX_W-1:0] idx_t;

  // one test: uop kinds, write-back flags, expected retirement
  typedef struct packed {
    logic [3:0]  n;
    logic [19:0] kinds;
    logic [9:0]  flag;
    logic [3:0]  n_ret;
    logic        exp_redir;
    logic [31:0] redir_pc;
    logic        exp_pair;
    logic        hold;
  } row_t;

  logic clk;
  logic rst_n;
  logic disp_req;
  logic [1:0] disp_valid;
  uop_pkg::uop_kind_t [1:0] disp_kind;
  logic [1:0][31:0] disp_pc;
  rob_pkg::preg_t [1:0] disp_preg;
  logic disp_ack;
  rob_pkg::rob_ptr_t [1:0] disp_idx;
  logic alu_req;
  logic alu_ack;
  uop_pkg::alu_result_t alu_data;
  logic mem_req;
  logic mem_ack;
  uop_pkg::mem_result_t mem_data;
  rob_pkg::retire_t [1:0] retire;
  logic redirect_valid;
  logic [31:0] redirect_pc;

  row_t rows [N_ROWS];
  row_t cur;
  int row_i;
  rob_pkg::rob_ptr_t tail_exp;
  rob_pkg::rob_ptr_t row_base;
  logic alloc_done [10];
  logic wb_go;
  logic alu_done;
  logic active;
  int retired_cnt;
  int pair_cycles;
  int redir_cnt;
  int errors;
  int test_err;
  int failed_tests;

  tb_clock_gen u_clk (.clk(clk), .rst_n(rst_n));

  rob_top dut0 (
    .clk (clk), .rst_n (rst_n),
    .disp_req (disp_req), .disp_valid (disp_valid), .disp_kind (disp_kind),
    .disp_pc (disp_pc), .disp_preg (disp_preg), .disp_ack (disp_ack),
    .disp_idx (disp_idx),
    .alu_req (alu_req), .alu_data (alu_data), .alu_ack (alu_ack),
    .mem_req (mem_req), .mem_data (mem_data), .mem_ack (mem_ack),
    .retire (retire), .redirect_valid (redirect_valid), .redirect_pc (redirect_pc)
  );

  function automatic logic [31:0] pc_of(input int r, input int i);
    return 32'h1000 + r * 32'h100 + i * 4;
  endfunction

  function automatic uop_pkg::uop_kind_t kind_of(input int i);
    return uop_pkg::uop_kind_t'(cur.kinds[2*i +: 2]);
  endfunction

  task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERR @%0t: %s got %h expected %h", $time, what, got, exp);
      errors++;
      test_err++;
    end
  endtask

  task automatic abort(input string why);
    $display("timeout at %0t: %s", $time, why);
    $display("RESULT: FAIL");
    $finish;
  endtask

  // 0 dispatch ack, 1 alu ack, 2 mem ack
  task automatic wait_ack(input int which, input logic level);
    int n;
    logic v;
    n = 0;
    v = ~level;
    while (v !== level) begin
      @(negedge clk);
      case (which)
        0: v = disp_ack;
        1: v = alu_ack;
        default: v = mem_ack;
      endcase
      n++;
      if (n > TIMEOUT) abort("a handshake ack never reached the expected level");
    end
  endtask

  // 0 write-back start, 1 alu side finished, 2 entry allocated
  task automatic wait_flag(input int which, input int i);
    int n;
    n = 0;
    while (!(which == 0 ? wb_go : which == 1 ? alu_done : alloc_done[i])) begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT) abort("a write-back never got its entry allocated");
    end
  endtask

  // ==============================
  // dispatch and write-back drivers
  // ==============================
  task automatic dispatch_row();
    for (int p = 0; p < cur.n / 2; p++) begin
      @(posedge clk);
      disp_req   <= 1'b1;
      disp_valid <= 2'b11;
      for (int s = 0; s < 2; s++) begin
        disp_kind[s] <= kind_of(2*p + s);
        disp_pc[s]   <= pc_of(row_i, 2*p + s);
        disp_preg[s] <= rob_pkg::preg_t'(2*p + s + 8);
      end
      // buffer full, ack must hold off until retirement frees room
      if (cur.hold && 2*p >= `ROB_DEPTH) begin
        repeat (8) begin
          @(negedge clk);
          check("ack while full", disp_ack, 1'b0);
        end
        wb_go = 1'b1;
      end
      wait_ack(0, 1'b1);
      check("disp_idx[0]", disp_idx[0], tail_exp);
      check("disp_idx[1]", disp_idx[1], rob_pkg::rob_ptr_t'(tail_exp + 1));
      tail_exp = tail_exp + 2;
      alloc_done[2*p] = 1'b1;
      alloc_done[2*p+1] = 1'b1;
      @(posedge clk);
      disp_req <= 1'b0;
      wait_ack(0, 1'b0);
    end
    wb_go = 1'b1;
  endtask

  task automatic alu_writebacks();
    int q[$];
    int j;
    int t;
    int n_mix;
    for (int i = 0; i < cur.n; i++) begin
      if (kind_of(i) == uop_pkg::UOP_ALU || kind_of(i) == uop_pkg::UOP_BRANCH) q.push_back(i);
    end
    // entries past the buffer depth only allocate after retirement, so they go last
    n_mix = 0;
    foreach (q[k]) begin
      if (q[k] < `ROB_DEPTH) n_mix++;
    end
    for (int k = n_mix - 1; k > 0; k--) begin
      j = $urandom % (k + 1);
      t = q[k];
      q[k] = q[j];
      q[j] = t;
    end
    wait_flag(0, 0);
    foreach (q[k]) begin
      wait_flag(2, q[k]);
      @(posedge clk);
      alu_req  <= 1'b1;
      alu_data <= '{idx: idx_t'(row_base + q[k]), redirect: cur.flag[q[k]],
                    target: pc_of(row_i, q[k]) + 32'h40};
      wait_ack(1, 1'b1);
      @(posedge clk);
      alu_req <= 1'b0;
      wait_ack(1, 1'b0);
    end
    alu_done = 1'b1;
  endtask

  // memory results in program order, so a store never blocks an older load
  task automatic mem_writebacks();
    wait_flag(0, 0);
    if (cur.exp_pair) wait_flag(1, 0);
    for (int i = 0; i < cur.n; i++) begin
      if (kind_of(i) == uop_pkg::UOP_LOAD || kind_of(i) == uop_pkg::UOP_STORE) begin
        wait_flag(2, i);
        @(posedge clk);
        mem_req  <= 1'b1;
        mem_data <= '{idx: idx_t'(row_base + i), kind: kind_of(i),
                      exc: cur.flag[i], fault_addr: pc_of(row_i, i)};
        wait_ack(2, 1'b1);
        if (kind_of(i) == uop_pkg::UOP_STORE) check("older retired before store ack",
                                                    retired_cnt >= i, 1'b1);
        @(posedge clk);
        mem_req <= 1'b0;
        wait_ack(2, 1'b0);
      end
    end
  endtask

  // retire and redirect monitor
  always @(negedge clk) begin
    if (rst_n && active) begin
      for (int s = 0; s < 2; s++) begin
        if (retire[s].valid) begin
          if (retired_cnt < cur.n_ret) begin
            check("retire pc", retire[s].pc, pc_of(row_i, retired_cnt));
            check("retire kind", retire[s].kind, kind_of(retired_cnt));
            check("retire preg", retire[s].preg, retired_cnt + 8);
          end else begin
            $display("unexpected retire of pc %h at %0t", retire[s].pc, $time);
            errors++;
            test_err++;
          end
          retired_cnt++;
        end
      end
      if (retire[0].valid && retire[1].valid) pair_cycles++;
      if (retire[0].valid && retire[0].kind == uop_pkg::UOP_BRANCH) begin
        check("slot 1 beside a branch", retire[1].valid, 1'b0);
      end
      if (redirect_valid) begin
        check("redirect expected", cur.exp_redir, 1'b1);
        check("redirect_pc", redirect_pc, cur.redir_pc);
        redir_cnt++;
      end
    end
  end

  // ==============================
  // table and main sequence
  // ==============================
  initial begin
    int n;
    disp_req = 1'b0;
    disp_valid = '0;
    disp_kind = '{default: uop_pkg::UOP_ALU};
    disp_pc = '0;
    disp_preg = '0;
    alu_req = 1'b0;
    alu_data = '0;
    mem_req = 1'b0;
    mem_data = '0;
    active = 1'b0;
    errors = 0;
    failed_tests = 0;
    tail_exp = '0;
    void'($urandom(32'hea17_7cdc));
    //         n  kinds      flag   ret redir  redir_pc       pair  hold
    rows[0] = {4'd6,  20'h00000, 10'b00, 4'd6,  1'b0, 32'h0,        1'b0, 1'b0};
    rows[1] = {4'd4,  20'h00012, 10'b00, 4'd4,  1'b0, 32'h0,        1'b1, 1'b0};
    rows[2] = {4'd4,  20'h00030, 10'b00, 4'd4,  1'b0, 32'h0,        1'b0, 1'b0};
    rows[3] = {4'd4,  20'h00008, 10'b10, 4'd2,  1'b1, `EXC_VECTOR,  1'b0, 1'b0};
    rows[4] = {4'd4,  20'h00004, 10'b10, 4'd2,  1'b1, 32'h1444,     1'b0, 1'b0};
    rows[5] = {4'd10, 20'h00000, 10'b00, 4'd10, 1'b0, 32'h0,        1'b0, 1'b1};
    n = 0;
    while (rst_n !== 1'b1) begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT) abort("reset was never released");
    end
    for (int r = 0; r < N_ROWS; r++) begin
      cur = rows[r];
      row_i = r;
      row_base = tail_exp;
      foreach (alloc_done[i]) alloc_done[i] = 1'b0;
      wb_go = 1'b0;
      alu_done = 1'b0;
      retired_cnt = 0;
      pair_cycles = 0;
      redir_cnt = 0;
      test_err = 0;
      active = 1'b1;
      fork
        dispatch_row();
        alu_writebacks();
        mem_writebacks();
      join
      n = 0;
      while (retired_cnt < cur.n_ret || redir_cnt < cur.exp_redir) begin
        @(negedge clk);
        n++;
        if (n > TIMEOUT) abort("expected retirement did not finish");
      end
      // quiet window catches stray retires from discarded entries
      repeat (6) @(negedge clk);
      active = 1'b0;
      check("redirect count", redir_cnt, cur.exp_redir);
      if (cur.exp_pair) check("dual retire seen", pair_cycles != 0, 1'b1);
      if (cur.exp_redir) tail_exp = '0;
      if (test_err != 0) failed_tests++;
      $display("test %0d: %s", r, test_err == 0 ? "ok" : "mismatch");
    end
    $display("tests %0d, failed %0d, errors %0d", N_ROWS, failed_tests, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+src
src/uop_pkg.sv
src/rob_pkg.sv
src/wb_port.sv
src/reorder_buffer.sv
src/commit_ctrl.sv
src/rob_top.sv
verification/tb_clock_gen.sv
verification/rob_properties.sv
verification/rob_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module rob_tb \
  --Mdir obj_dir -o rob_sim > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }

./obj_dir/rob_sim > sim.log 2>&1
cat sim.log

grep -qx "RESULT: PASS" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
